/* logic/axi4s_pkg.sv */
// Stream beat definitions for the retimed AXI4-Stream slice
//   DATA_BYTES, ID_WID, DEST_WID, USER_WID field widths
//   axi4s_beat_t, one beat without its valid bit

package axi4s_pkg;

    // Bytes carried per beat
    localparam int DATA_BYTES = 4;

    // Sideband widths
    localparam int ID_WID   = 4;
    localparam int DEST_WID = 4;
    localparam int USER_WID = 8;

    // Field types
    typedef logic [DATA_BYTES-1:0][7:0] tdata_t;
    typedef logic [DATA_BYTES-1:0]      tkeep_t;
    typedef logic [ID_WID-1:0]          tid_t;
    typedef logic [DEST_WID-1:0]        tdest_t;
    typedef logic [USER_WID-1:0]        tuser_t;

    // One stream beat
    // Sideband in the upper bits, data at the bottom
    typedef struct packed {
        tuser_t tuser;
        tdest_t tdest;
        tid_t   tid;
        logic   tlast;
        tkeep_t tkeep;
        tdata_t tdata;
    } axi4s_beat_t;

endpackage : axi4s_pkg

/* logic/pipe_pkg.sv */
// Control side definitions of the retimed slice
//   CNT_WID, width of the statistics counters
//   pipe_status_t, status word seen by the outside

package pipe_pkg;

    // Statistics counter width, counters wrap
    localparam int CNT_WID = 16;

    typedef logic [CNT_WID-1:0] cnt_t;

    // Status word
    typedef struct packed {
        // Output beats accepted downstream
        cnt_t beat_count;
        // Output beats with tlast accepted downstream
        cnt_t pkt_count;
        // Sticky, set by any skid buffer overflow
        logic oflow_seen;
    } pipe_status_t;

endpackage : pipe_pkg

/* logic/fifo_small_prefetch.sv */
// Small register-array FIFO
//   Payload type given by the DATA_T parameter
//   Head entry always presented on rd_data (prefetched)
//   wr_rdy promises room for PIPELINE_DEPTH+1 more writes
//   Writes into a full FIFO are dropped and flagged on oflow

`timescale 1ns/1ns

module fifo_small_prefetch #(
    parameter type DATA_T         = logic [7:0],
    parameter int  PIPELINE_DEPTH = 1
) (
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  wr,
    input  DATA_T wr_data,
    output logic  wr_rdy,
    output logic  oflow,
    input  logic  rd,
    output logic  rd_rdy,
    output DATA_T rd_data
);

    // Room for the in-flight writes plus one spare entry each side
    localparam int DEPTH    = PIPELINE_DEPTH + 2;
    localparam int PTR_WID  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID  = $clog2(DEPTH + 1);
    // Free entries needed before ready is offered
    localparam int FREE_MIN = PIPELINE_DEPTH + 1;

    typedef logic [PTR_WID-1:0] ptr_t;
    typedef logic [CNT_WID-1:0] cnt_t;

    DATA_T mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (count == cnt_t'(DEPTH));
    assign empty = (count == '0);

    // Pop only when there is something to give
    assign rd_en = rd && !empty;
    // A pop in the same cycle frees the slot being written
    assign wr_en = wr && (!full || rd_en);

    // Dropped write, one cycle pulse per lost beat
    assign oflow = wr && full && !rd_en;

    // Headroom check on occupancy
    assign wr_rdy = ((DEPTH - int'(count)) >= FREE_MIN);

    // Read side
    assign rd_rdy  = !empty;
    assign rd_data = mem[rd_ptr];

    // Storage, no reset needed on payload
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : fifo_small_prefetch

/* logic/axi4s_skid_buffer.sv */
// Skid buffer for stream beats with relaxed ready
//   Write side takes a beat on every wr_valid, ready or not
//   buf_ready high means room for SKID more beats
//   Read side is a normal valid/ready stream

`timescale 1ns/1ns

module axi4s_skid_buffer
    import axi4s_pkg::*;
#(
    // Beats that may still arrive after buf_ready drops
    parameter int SKID = 2
) (
    input  logic        aclk,
    input  logic        rst_n,
    // Relaxed write side, no back-pressure
    input  logic        wr_valid,
    input  axi4s_beat_t wr_beat,
    output logic        buf_ready,
    // Write seen with no room left
    output logic        oflow,
    // Standard read side
    output logic        rd_valid,
    output axi4s_beat_t rd_beat,
    input  logic        rd_ready
);

    // FIFO sized to absorb SKID beats in flight
    // wr_rdy there already carries the headroom rule
    fifo_small_prefetch #(
        .DATA_T         (axi4s_beat_t),
        .PIPELINE_DEPTH (SKID)
    ) u_fifo (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .wr      (wr_valid),
        .wr_data (wr_beat),
        .wr_rdy  (buf_ready),
        .oflow   (oflow),
        // Pop on the read handshake
        .rd      (rd_ready),
        .rd_rdy  (rd_valid),
        .rd_data (rd_beat)
    );

endmodule : axi4s_skid_buffer

/* logic/axi4s_reg_pipe.sv */
// Forward register pipe for stream beats
//   STAGES flops on valid and on the beat, no stall input
//   Beat flops load only behind a valid bit

`timescale 1ns/1ns

module axi4s_reg_pipe
    import axi4s_pkg::*;
#(
    parameter int STAGES = 2
) (
    input  logic        aclk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  axi4s_beat_t in_beat,
    output logic        out_valid,
    output axi4s_beat_t out_beat
);

    logic [STAGES-1:0] vld_q;
    axi4s_beat_t       beat_q [STAGES];

    // Valid chain, cleared on reset
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= in_valid;
            for (int i = 1; i < STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Payload chain
    // Empty slots keep their old contents to save toggling
    always_ff @(posedge aclk) begin
        if (in_valid) begin
            beat_q[0] <= in_beat;
        end
        for (int i = 1; i < STAGES; i++) begin
            if (vld_q[i-1]) begin
                beat_q[i] <= beat_q[i-1];
            end
        end
    end

    assign out_valid = vld_q[STAGES-1];
    assign out_beat  = beat_q[STAGES-1];

endmodule : axi4s_reg_pipe

/* logic/pipe_ctrl.sv */
// Control for the retimed slice
//   Ready delay chain from the skid buffer back to the source
//   Beat and packet counters on the output handshake
//   Sticky overflow flag

`timescale 1ns/1ns

module pipe_ctrl
    import pipe_pkg::*;
#(
    parameter int STAGES = 2
) (
    input  logic         aclk,
    input  logic         rst_n,
    // Ready from the skid buffer, delayed toward the source
    input  logic         buf_ready,
    output logic         in_ready,
    // Overflow pulse from the skid buffer
    input  logic         oflow,
    // Output handshake, tlast split off from the beat
    input  logic         out_valid,
    input  logic         out_ready,
    input  logic         out_last,
    output pipe_status_t status
);

    logic [STAGES-1:0] rdy_q;
    logic              out_xfer;
    pipe_status_t      status_q;

    // Ready travels back through STAGES flops
    // Zero on reset, so the source waits until the chain has filled
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_q <= '0;
        end else begin
            rdy_q[0] <= buf_ready;
            for (int i = 1; i < STAGES; i++) begin
                rdy_q[i] <= rdy_q[i-1];
            end
        end
    end

    assign in_ready = rdy_q[STAGES-1];

    // Beat leaves the slice
    assign out_xfer = out_valid && out_ready;

    // Statistics, both counters wrap
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else begin
            if (out_xfer) begin
                status_q.beat_count <= status_q.beat_count + 1'b1;
            end
            if (out_xfer && out_last) begin
                status_q.pkt_count <= status_q.pkt_count + 1'b1;
            end
            // Held until the next reset
            if (oflow) begin
                status_q.oflow_seen <= 1'b1;
            end
        end
    end

    assign status = status_q;

endmodule : pipe_ctrl

/* logic/axi4s_retime_top.sv */
// Retimed AXI4-Stream pipeline slice
//   Forward register pipe for beats
//   Skid buffer sized from STAGES to catch in-flight beats
//   Control with delayed ready, counters and overflow flag

`timescale 1ns/1ns

module axi4s_retime_top
    import axi4s_pkg::*;
    import pipe_pkg::*;
#(
    // Register stages each way, 1 to 4
    parameter int STAGES = 2
) (
    input  logic         aclk,
    input  logic         rst_n,
    // Input stream
    input  logic         in_valid,
    input  axi4s_beat_t  in_beat,
    output logic         in_ready,
    // Output stream
    output logic         out_valid,
    output axi4s_beat_t  out_beat,
    input  logic         out_ready,
    output pipe_status_t status
);

    // STAGES beats in the pipe plus STAGES accepted while ready travels back
    localparam int SKID = 2 * STAGES;

    logic        pipe_in_valid;
    logic        wr_valid;
    axi4s_beat_t wr_beat;
    logic        buf_ready;
    logic        oflow;

    // Only beats that really transfer enter the pipe
    assign pipe_in_valid = in_valid && in_ready;

    axi4s_reg_pipe #(
        .STAGES (STAGES)
    ) u_pipe (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (pipe_in_valid),
        .in_beat   (in_beat),
        .out_valid (wr_valid),
        .out_beat  (wr_beat)
    );

    // Relaxed handshake stays inside, standard stream comes out
    axi4s_skid_buffer #(
        .SKID (SKID)
    ) u_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_beat   (wr_beat),
        .buf_ready (buf_ready),
        .oflow     (oflow),
        .rd_valid  (out_valid),
        .rd_beat   (out_beat),
        .rd_ready  (out_ready)
    );

    pipe_ctrl #(
        .STAGES (STAGES)
    ) u_ctrl (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .buf_ready (buf_ready),
        .in_ready  (in_ready),
        .oflow     (oflow),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_beat.tlast),
        .status    (status)
    );

endmodule : axi4s_retime_top

/* tb/tb_stim_table.svh */
// Packet table for the retimed slice testbench
//   stall_t, output stall modes
//   stim_row_t, one packet row
//   STIM, packets in send order with expected last-beat tkeep

`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

// How out_ready behaves while a packet leaves the slice
typedef enum logic [1:0] {
    // out_ready held high
    STALL_NONE,
    // out_ready random each cycle
    STALL_RANDOM,
    // out_ready low 12 cycles of every 16
    STALL_LONG
} stall_t;

// One packet
// last_keep is the tkeep expected on the final beat
typedef struct packed {
    logic [7:0] len;
    tid_t       tid;
    tdest_t     tdest;
    stall_t     mode;
    tkeep_t     last_keep;
} stim_row_t;

localparam int NUM_ROWS = 8;

// Columns: length, tid, tdest, stall mode, tkeep on the last beat
// Last tkeep keeps the first length-mod-4 bytes, all ones for zero
localparam stim_row_t STIM [NUM_ROWS] = '{
    '{8'd1,  4'h1, 4'h2, STALL_NONE,   4'b0001},
    '{8'd4,  4'h3, 4'h5, STALL_NONE,   4'b1111},
    '{8'd7,  4'h2, 4'h9, STALL_RANDOM, 4'b0111},
    '{8'd16, 4'h6, 4'h1, STALL_LONG,   4'b1111},
    '{8'd3,  4'hf, 4'h0, STALL_NONE,   4'b0111},
    '{8'd22, 4'h4, 4'h7, STALL_RANDOM, 4'b0011},
    '{8'd10, 4'h9, 4'he, STALL_LONG,   4'b0011},
    '{8'd5,  4'h0, 4'h3, STALL_RANDOM, 4'b0001}
};

`endif

/* tb/tb_axi4s_retime.sv */
// Testbench for the retimed AXI4-Stream slice
//   Clock, reset and idle checks
//   Packet driver and output ready patterns per stall mode
//   Monitor with beat, latency and hold checks
//   Closing status checks and report

`timescale 1ns/1ns

module tb_axi4s_retime
    import axi4s_pkg::*;
    import pipe_pkg::*;
();

    localparam int STAGES     = 2;
    localparam int WAIT_LIMIT = 1000;

    `include "tb_stim_table.svh"

    logic         aclk;
    logic         rst_n;
    logic         in_valid;
    axi4s_beat_t  in_beat;
    logic         in_ready;
    logic         out_valid;
    axi4s_beat_t  out_beat;
    logic         out_ready;
    pipe_status_t status;

    // Rising edges seen so far
    int cyc = 0;
    // Driver side bookkeeping
    int tx_total = 0;
    int tx_time [NUM_ROWS];
    bit lat_check [NUM_ROWS];
    int checks = 0;
    int errors = 0;
    bit timed_out = 1'b0;
    // Monitor side bookkeeping
    int rx_total = 0;
    int rx_row = 0;
    int rx_idx = 0;
    int mon_checks = 0;
    int mon_errors = 0;
    bit hold_pend = 1'b0;
    axi4s_beat_t hold_beat;

    axi4s_retime_top #(
        .STAGES (STAGES)
    ) uut (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready),
        .status    (status)
    );

    // 40 ns clock
    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) cyc <= cyc + 1;

    // Beat content rule of the table
    function automatic axi4s_beat_t build_beat(input int row, input int idx);
        axi4s_beat_t beat;
        beat       = '0;
        beat.tdata = tdata_t'(row * 256 + idx);
        beat.tlast = (idx == int'(STIM[row].len) - 1);
        // Only the last beat may be partial
        beat.tkeep = beat.tlast ? STIM[row].last_keep : '1;
        beat.tid   = STIM[row].tid;
        beat.tdest = STIM[row].tdest;
        beat.tuser = tuser_t'(idx);
        return beat;
    endfunction

    function automatic bit check_value(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
        bit ok;
        ok = 1'b1;
        assert (got === exp) else begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            ok = 1'b0;
        end
        return ok;
    endfunction

    // Field by field compare, returns the number of bad fields
    function automatic int count_beat_errors(input axi4s_beat_t got, input axi4s_beat_t exp);
        int bad;
        bad = 0;
        if (!check_value("out_beat.tdata", 32'(got.tdata), 32'(exp.tdata))) bad++;
        if (!check_value("out_beat.tkeep", 32'(got.tkeep), 32'(exp.tkeep))) bad++;
        if (!check_value("out_beat.tlast", 32'(got.tlast), 32'(exp.tlast))) bad++;
        if (!check_value("out_beat.tid", 32'(got.tid), 32'(exp.tid))) bad++;
        if (!check_value("out_beat.tdest", 32'(got.tdest), 32'(exp.tdest))) bad++;
        if (!check_value("out_beat.tuser", 32'(got.tuser), 32'(exp.tuser))) bad++;
        return bad;
    endfunction

    function automatic int total_beats();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += int'(STIM[r].len);
        end
        return sum;
    endfunction

    task automatic end_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 checks + mon_checks, errors + mon_errors, timed_out);
        if (errors + mon_errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string why);
        timed_out = 1'b1;
        $display("timeout: %s", why);
        end_run();
    endtask

    // Slice quiet, nothing counted
    task automatic check_idle();
        checks += 5;
        if (!check_value("out_valid", 32'(out_valid), 32'd0)) errors++;
        if (!check_value("in_ready", 32'(in_ready), 32'd0)) errors++;
        if (!check_value("status.beat_count", 32'(status.beat_count), 32'd0)) errors++;
        if (!check_value("status.pkt_count", 32'(status.pkt_count), 32'd0)) errors++;
        if (!check_value("status.oflow_seen", 32'(status.oflow_seen), 32'd0)) errors++;
    endtask

    // Called on a rising edge, returns on the edge that takes the beat
    task automatic send_beat(input int row, input int idx);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_beat  <= build_beat(row, idx);
        @(negedge aclk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("in_ready stayed low while sending");
            @(negedge aclk);
        end
        if (idx == 0) tx_time[row] = cyc;
        tx_total++;
        @(posedge aclk);
    endtask

    // Idle the input until every sent beat has left the slice
    task automatic wait_drain();
        int waited;
        waited = 0;
        in_valid <= 1'b0;
        while (rx_total != tx_total) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("slice did not drain its beats");
            @(posedge aclk);
        end
    endtask

    // out_ready pattern follows the packet now at the output
    initial begin
        int phase;
        stall_t mode;
        // Fixed seed for the random stall pattern
        void'($urandom(32'h9466c042));
        phase = 0;
        out_ready = 1'b0;
        forever begin
            @(posedge aclk);
            mode = (rx_row < NUM_ROWS) ? STIM[rx_row].mode : STALL_NONE;
            if (!rst_n) begin
                out_ready <= 1'b0;
            end else begin
                case (mode)
                    STALL_RANDOM: out_ready <= ($urandom % 2) == 1;
                    // Long stalls fill the buffer and push ready back
                    STALL_LONG: begin
                        out_ready <= (phase % 16) >= 12;
                        phase++;
                    end
                    default: out_ready <= 1'b1;
                endcase
            end
        end
    end

    // Monitor, sampled half a cycle before each edge
    always @(negedge aclk) begin
        if (rst_n) begin
            // Stalled beat must hold over the edge
            if (hold_pend) begin
                mon_checks++;
                if (!check_value("out_valid held", 32'(out_valid), 32'd1)) mon_errors++;
                mon_errors += count_beat_errors(out_beat, hold_beat);
            end
            hold_pend = out_valid && !out_ready;
            hold_beat = out_beat;
            if (out_valid && out_ready) begin
                mon_checks++;
                assert (rx_row < NUM_ROWS) else begin
                    $display("an output beat arrived after the last packet");
                    mon_errors++;
                end
                if (rx_row < NUM_ROWS) begin
                    mon_errors += count_beat_errors(out_beat, build_beat(rx_row, rx_idx));
                    // Input handshake to output handshake, empty slice
                    if (rx_idx == 0 && lat_check[rx_row]) begin
                        mon_checks++;
                        if (!check_value("first beat latency", 32'(cyc - tx_time[rx_row]),
                                         32'(STAGES + 1))) mon_errors++;
                    end
                    rx_idx++;
                    if (rx_idx == int'(STIM[rx_row].len)) begin
                        rx_row++;
                        rx_idx = 0;
                    end
                end
                rx_total++;
            end
        end
    end

    initial begin
        int waited;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        // Reset low over two rising edges
        repeat (2) begin
            @(negedge aclk);
            check_idle();
        end
        @(posedge aclk);
        rst_n <= 1'b1;
        // First cycle out of reset is still idle
        @(negedge aclk);
        check_idle();
        // Ready climbs back through the delay chain
        waited = 0;
        while (!in_ready) begin
            if (waited > WAIT_LIMIT) stop_on_timeout("in_ready never rose after reset");
            @(negedge aclk);
            waited++;
        end
        checks++;
        if (!check_value("cycles to in_ready", 32'(waited), 32'(STAGES))) errors++;
        @(posedge aclk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            // Unstalled packets start into an empty slice for the latency check
            if (STIM[r].mode == STALL_NONE) begin
                wait_drain();
                lat_check[r] = 1'b1;
            end
            for (int i = 0; i < int'(STIM[r].len); i++) begin
                send_beat(r, i);
            end
        end
        wait_drain();
        repeat (4) @(negedge aclk);
        // Closing totals
        checks += 4;
        if (!check_value("rx_total", 32'(rx_total), 32'(total_beats()))) errors++;
        if (!check_value("status.beat_count", 32'(status.beat_count),
                         32'(total_beats()))) errors++;
        if (!check_value("status.pkt_count", 32'(status.pkt_count), 32'(NUM_ROWS))) errors++;
        if (!check_value("status.oflow_seen", 32'(status.oflow_seen), 32'd0)) errors++;
        end_run();
    end

endmodule : tb_axi4s_retime

/* build.f */
+incdir+tb
logic/axi4s_pkg.sv
logic/pipe_pkg.sv
logic/fifo_small_prefetch.sv
logic/axi4s_skid_buffer.sv
logic/axi4s_reg_pipe.sv
logic/pipe_ctrl.sv
logic/axi4s_retime_top.sv
tb/tb_axi4s_retime.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the retimed slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_axi4s_retime \
    -f build.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

# Result taken from the simulation log
if grep -q "All tests passed!" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi
